/* rv_isa_pkg.sv */
`default_nettype none

package rv_isa_pkg;

  // ============================================================
  // Instruction encoding
  // ============================================================

  localparam logic [6:0] opc_op_imm = 7'b0010011;
  localparam logic [6:0] opc_op     = 7'b0110011;
  localparam logic [6:0] opc_lui    = 7'b0110111;
  localparam logic [6:0] opc_system = 7'b1110011;

  localparam logic [2:0] f3_add_sub = 3'b000;
  localparam logic [2:0] f3_priv    = 3'b000;
  localparam logic [2:0] f3_csrrw   = 3'b001;
  localparam logic [2:0] f3_csrrs   = 3'b010;

  localparam logic [6:0] f7_add = 7'b0000000;
  localparam logic [6:0] f7_sub = 7'b0100000;

  // funct12 of the privileged SYSTEM forms
  localparam logic [11:0] f12_ecall = 12'h000;
  localparam logic [11:0] f12_mret  = 12'h302;

  // ============================================================
  // Machine CSRs
  // ============================================================

  localparam logic [11:0] csr_mstatus   = 12'h300;
  localparam logic [11:0] csr_mtvec     = 12'h305;
  localparam logic [11:0] csr_mepc      = 12'h341;
  localparam logic [11:0] csr_mcause    = 12'h342;
  localparam logic [11:0] csr_mvendorid = 12'hf11;
  localparam logic [11:0] csr_marchid   = 12'hf12;

  localparam logic [31:0] mstatus_reset   = 32'h0000_1800;
  localparam logic [31:0] mcause_ecall    = 32'd11;
  localparam logic [31:0] mvendorid_value = 32'h7973_7978;
  localparam logic [31:0] marchid_value   = 32'h017d_c685;

  typedef enum logic [3:0] {
    op_addi,
    op_add,
    op_sub,
    op_lui,
    op_csrrw,
    op_csrrs,
    op_ecall,
    op_mret,
    op_nop
  } rv_op_e;

endpackage

`default_nettype wire

/* rv_pipe_pkg.sv */
`default_nettype none

package rv_pipe_pkg;

  // Instruction as delivered by the stimulus
  typedef struct packed {
    logic [31:0] pc;
    logic [31:0] word;
  } inst_t;

  // Decode to execute
  typedef struct packed {
    rv_isa_pkg::rv_op_e op;
    logic [31:0]        pc;
    logic [3:0]         rd;
    logic [31:0]        src1;
    // Holds the CSR read value for CSR ops, ecall and mret
    logic [31:0]        imm_or_src2;
    logic [11:0]        csr_addr;
    logic               writes_csr;
  } dx_t;

  // Execute to commit, and the retire record
  typedef struct packed {
    logic [31:0] pc;
    logic [3:0]  rd;
    logic [31:0] rd_wdata;
    logic        rd_wen;
    logic [11:0] csr_addr;
    logic [31:0] csr_wdata;
    logic        csr_wen;
    logic        is_ecall;
    logic        is_mret;
    logic [31:0] next_pc;
  } xw_t;

  typedef struct packed {
    logic [3:0] rs1;
    logic [3:0] rs2;
  } rd_gpr_t;

endpackage

`default_nettype wire

/* rv_pipe_reg.sv */
`timescale 1ns/100ps
`default_nettype none

module rv_pipe_reg #(
  parameter type payload_t = logic [31:0]
) (
  input  wire      clk,
  input  wire      arst_n,
  input  wire      in_valid,
  output logic     in_ready,
  input  wire      payload_t in_data,
  output logic     out_valid,
  input  wire      out_ready,
  output payload_t out_data
);

  logic     full;
  payload_t data_q;

  // Accept when empty or when the held entry leaves this cycle
  assign in_ready  = !full || out_ready;
  assign out_valid = full;
  assign out_data  = data_q;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      full <= 1'b0;
    end else if (in_ready) begin
      full <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid && in_ready) begin
      data_q <= in_data;
    end
  end

  a_out_stable : assert property (@(posedge clk) disable iff (!arst_n)
    out_valid && !out_ready |=> out_valid && $stable(out_data));

endmodule

`default_nettype wire

/* rv_decode.sv */
`timescale 1ns/100ps
`default_nettype none

module rv_decode #(
  parameter int n_gpr = 16
) (
  input  wire                  clk,
  input  wire                  arst_n,
  input  wire                  inst_valid,
  output logic                 inst_ready,
  input  wire rv_pipe_pkg::inst_t inst,
  output rv_pipe_pkg::rd_gpr_t rd_req,
  input  wire [31:0]           src1,
  input  wire [31:0]           src2,
  output logic [11:0]          csr_raddr,
  input  wire [31:0]           csr_rdata,
  output logic                 dx_valid,
  input  wire                  dx_ready,
  output rv_pipe_pkg::dx_t     dx,
  input  wire                  x_busy,
  input  wire                  w_busy,
  input  wire [3:0]            x_rd,
  input  wire [3:0]            w_rd,
  input  wire                  x_csr,
  input  wire                  w_csr
);

  import rv_isa_pkg::*;

  logic [31:0] word;
  logic [6:0]  opcode;
  logic [2:0]  funct3;
  rv_op_e      op;
  logic        uses_rs1;
  logic        uses_rs2;
  logic        writes_rd;
  logic        is_csr_op;
  logic        is_trap_op;
  logic        gpr_hazard;
  logic        csr_hazard;
  logic        stall;

  assign word   = inst.word;
  assign opcode = word[6:0];
  assign funct3 = word[14:12];

  // ============================================================
  // Operation decode
  // ============================================================

  always_comb begin
    op        = op_nop;
    uses_rs1  = 1'b0;
    uses_rs2  = 1'b0;
    writes_rd = 1'b0;
    case (opcode)
      opc_op_imm: begin
        if (funct3 == f3_add_sub) begin
          op        = op_addi;
          uses_rs1  = 1'b1;
          writes_rd = 1'b1;
        end
      end
      opc_op: begin
        if (funct3 == f3_add_sub && (word[31:25] == f7_add || word[31:25] == f7_sub)) begin
          op        = (word[31:25] == f7_sub) ? op_sub : op_add;
          uses_rs1  = 1'b1;
          uses_rs2  = 1'b1;
          writes_rd = 1'b1;
        end
      end
      opc_lui: begin
        op        = op_lui;
        writes_rd = 1'b1;
      end
      opc_system: begin
        if (funct3 == f3_csrrw || funct3 == f3_csrrs) begin
          op        = (funct3 == f3_csrrw) ? op_csrrw : op_csrrs;
          uses_rs1  = 1'b1;
          writes_rd = 1'b1;
        end else if (funct3 == f3_priv && word[19:7] == '0) begin
          if (word[31:20] == f12_ecall) op = op_ecall;
          else if (word[31:20] == f12_mret) op = op_mret;
        end
      end
      default: ;
    endcase
  end

  assign is_csr_op  = (op == op_csrrw) || (op == op_csrrs);
  assign is_trap_op = (op == op_ecall) || (op == op_mret);

  assign rd_req.rs1 = word[18:15];
  assign rd_req.rs2 = word[23:20];

  // ecall and mret fetch their target through the CSR read port
  assign csr_raddr = (op == op_ecall) ? csr_mtvec :
                     (op == op_mret)  ? csr_mepc  : word[31:20];

  // ============================================================
  // Interlock
  // ============================================================

  always_comb begin
    gpr_hazard = 1'b0;
    if (uses_rs1 && rd_req.rs1 != '0) begin
      gpr_hazard |= (x_busy && x_rd == rd_req.rs1) || (w_busy && w_rd == rd_req.rs1);
    end
    if (uses_rs2 && rd_req.rs2 != '0) begin
      gpr_hazard |= (x_busy && x_rd == rd_req.rs2) || (w_busy && w_rd == rd_req.rs2);
    end
  end

  assign csr_hazard = (is_csr_op || is_trap_op) && ((x_busy && x_csr) || (w_busy && w_csr));
  assign stall      = gpr_hazard || csr_hazard;

  assign inst_ready = dx_ready && !stall;
  assign dx_valid   = inst_valid && !stall;

  always_comb begin
    dx.op          = op;
    dx.pc          = inst.pc;
    dx.rd          = writes_rd ? word[10:7] : 4'd0;
    dx.src1        = uses_rs1 ? src1 : 32'd0;
    dx.csr_addr    = word[31:20];
    dx.writes_csr  = is_csr_op || is_trap_op;
    dx.imm_or_src2 = {{20{word[31]}}, word[31:20]};
    if (op == op_lui) dx.imm_or_src2 = {word[31:12], 12'd0};
    else if (uses_rs2) dx.imm_or_src2 = src2;
    else if (is_csr_op || is_trap_op) dx.imm_or_src2 = csr_rdata;
  end

  // A source written by the retiring item must not be taken on the same edge
  a_wb_interlock : assert property (@(posedge clk) disable iff (!arst_n)
    inst_valid && w_busy && uses_rs1 && rd_req.rs1 != '0 && w_rd == rd_req.rs1
    |-> !inst_ready);

  a_reg_range : assert property (@(posedge clk) disable iff (!arst_n)
    inst_valid && uses_rs1 |-> int'(word[19:15]) < n_gpr);

endmodule

`default_nettype wire

/* rv_execute.sv */
`timescale 1ns/100ps
`default_nettype none

module rv_execute (
  input  wire rv_pipe_pkg::dx_t dx,
  output rv_pipe_pkg::xw_t      xw
);

  import rv_isa_pkg::*;

  logic [31:0] sum;
  logic [31:0] diff;
  logic [31:0] old_csr;

  assign sum     = dx.src1 + dx.imm_or_src2;
  assign diff    = dx.src1 - dx.imm_or_src2;
  assign old_csr = dx.imm_or_src2;

  always_comb begin
    xw.pc        = dx.pc;
    xw.rd        = dx.rd;
    xw.rd_wdata  = 32'd0;
    xw.rd_wen    = 1'b0;
    xw.csr_addr  = dx.csr_addr;
    xw.csr_wdata = 32'd0;
    // Also set for ecall and mret, which commit takes with priority
    xw.csr_wen   = dx.writes_csr;
    xw.is_ecall  = 1'b0;
    xw.is_mret   = 1'b0;
    xw.next_pc   = dx.pc + 32'd4;

    case (dx.op)
      op_addi, op_add: begin
        xw.rd_wdata = sum;
        xw.rd_wen   = 1'b1;
      end
      op_sub: begin
        xw.rd_wdata = diff;
        xw.rd_wen   = 1'b1;
      end
      op_lui: begin
        xw.rd_wdata = dx.imm_or_src2;
        xw.rd_wen   = 1'b1;
      end
      op_csrrw: begin
        xw.rd_wdata  = old_csr;
        xw.rd_wen    = 1'b1;
        xw.csr_wdata = dx.src1;
      end
      op_csrrs: begin
        xw.rd_wdata  = old_csr;
        xw.rd_wen    = 1'b1;
        xw.csr_wdata = dx.src1 | old_csr;
      end
      // Trap entry jumps to mtvec
      op_ecall: begin
        xw.is_ecall = 1'b1;
        xw.next_pc  = old_csr;
      end
      op_mret: begin
        xw.is_mret = 1'b1;
        xw.next_pc = old_csr;
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

/* rv_gpr_csr.sv */
`timescale 1ns/100ps
`default_nettype none

module rv_gpr_csr #(
  parameter int n_gpr = 16
) (
  input  wire                       clk,
  input  wire                       arst_n,
  input  wire rv_pipe_pkg::rd_gpr_t rd_req,
  output logic [31:0]               src1,
  output logic [31:0]               src2,
  input  wire [11:0]                csr_raddr,
  output logic [31:0]               csr_rdata,
  input  wire                       commit_en,
  input  wire rv_pipe_pkg::xw_t     commit
);

  import rv_isa_pkg::*;

  logic [31:0] regs [n_gpr];
  logic [31:0] mtvec;
  logic [31:0] mepc;
  logic [31:0] mstatus;
  logic [31:0] mstatus_mret;

  // ============================================================
  // General registers
  // ============================================================

  assign src1 = regs[rd_req.rs1];
  assign src2 = regs[rd_req.rs2];

  // x0 is cleared by reset and never written
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < n_gpr; i++) begin
        regs[i] <= 32'd0;
      end
    end else if (commit_en && commit.rd_wen && commit.rd != 4'd0) begin
      regs[commit.rd] <= commit.rd_wdata;
    end
  end

  // ============================================================
  // Machine CSRs
  // ============================================================

  always_comb begin
    case (csr_raddr)
      csr_mstatus:   csr_rdata = mstatus;
      csr_mtvec:     csr_rdata = mtvec;
      csr_mepc:      csr_rdata = mepc;
      csr_mcause:    csr_rdata = mcause_ecall;
      csr_mvendorid: csr_rdata = mvendorid_value;
      csr_marchid:   csr_rdata = marchid_value;
      default:       csr_rdata = 32'd0;
    endcase
  end

  // MIE takes MPIE, MPIE is set, MPP drops to user
  always_comb begin
    mstatus_mret        = mstatus;
    mstatus_mret[3]     = mstatus[7];
    mstatus_mret[7]     = 1'b1;
    mstatus_mret[12:11] = 2'b00;
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      mtvec   <= 32'd0;
      mepc    <= 32'd0;
      mstatus <= mstatus_reset;
    end else if (commit_en) begin
      if (commit.is_ecall) begin
        mepc    <= commit.pc;
        mstatus <= mstatus_reset;
      end else if (commit.is_mret) begin
        mstatus <= mstatus_mret;
      end else if (commit.csr_wen) begin
        case (commit.csr_addr)
          csr_mtvec:   mtvec   <= commit.csr_wdata;
          csr_mepc:    mepc    <= commit.csr_wdata;
          csr_mstatus: mstatus <= commit.csr_wdata;
          // mcause and the ID registers are read only here
          default: ;
        endcase
      end
    end
  end

  a_one_trap_op : assert property (@(posedge clk) disable iff (!arst_n)
    commit_en |-> !(commit.is_ecall && commit.is_mret));

endmodule

`default_nettype wire

/* rv_core_top.sv */
`timescale 1ns/100ps
`default_nettype none

module rv_core_top #(
  parameter int n_gpr = 16
) (
  input  wire                     clk,
  input  wire                     arst_n,
  input  wire                     inst_valid,
  output logic                    inst_ready,
  input  wire rv_pipe_pkg::inst_t inst,
  output logic                    retire_valid,
  input  wire                     retire_ready,
  output rv_pipe_pkg::xw_t        retire
);

  import rv_pipe_pkg::*;

  rd_gpr_t     rd_req;
  logic [31:0] src1;
  logic [31:0] src2;
  logic [11:0] csr_raddr;
  logic [31:0] csr_rdata;

  dx_t  dx_d;
  logic dx_d_valid;
  logic dx_d_ready;
  dx_t  dx_q;
  logic dx_q_valid;
  xw_t  xw_d;
  logic xw_d_ready;

  // ============================================================
  // Decode, operand read and interlock
  // ============================================================

  rv_decode #(
    .n_gpr (n_gpr)
  ) u_decode (
    .clk        (clk),
    .arst_n     (arst_n),
    .inst_valid (inst_valid),
    .inst_ready (inst_ready),
    .inst       (inst),
    .rd_req     (rd_req),
    .src1       (src1),
    .src2       (src2),
    .csr_raddr  (csr_raddr),
    .csr_rdata  (csr_rdata),
    .dx_valid   (dx_d_valid),
    .dx_ready   (dx_d_ready),
    .dx         (dx_d),
    .x_busy     (dx_q_valid),
    .w_busy     (retire_valid),
    .x_rd       (dx_q.rd),
    .w_rd       (retire.rd),
    .x_csr      (dx_q.writes_csr),
    .w_csr      (retire.csr_wen)
  );

  rv_pipe_reg #(
    .payload_t (dx_t)
  ) u_dx_reg (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_valid  (dx_d_valid),
    .in_ready  (dx_d_ready),
    .in_data   (dx_d),
    .out_valid (dx_q_valid),
    .out_ready (xw_d_ready),
    .out_data  (dx_q)
  );

  rv_execute u_execute (
    .dx (dx_q),
    .xw (xw_d)
  );

  // Last stage output is the retire port
  rv_pipe_reg #(
    .payload_t (xw_t)
  ) u_xw_reg (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_valid  (dx_q_valid),
    .in_ready  (xw_d_ready),
    .in_data   (xw_d),
    .out_valid (retire_valid),
    .out_ready (retire_ready),
    .out_data  (retire)
  );

  rv_gpr_csr #(
    .n_gpr (n_gpr)
  ) u_gpr_csr (
    .clk       (clk),
    .arst_n    (arst_n),
    .rd_req    (rd_req),
    .src1      (src1),
    .src2      (src2),
    .csr_raddr (csr_raddr),
    .csr_rdata (csr_rdata),
    .commit_en (retire_valid && retire_ready),
    .commit    (retire)
  );

endmodule

`default_nettype wire

/* tb_clk_gen.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_clk_gen #(
  parameter real period_ns    = 8.0,
  parameter int  reset_cycles = 2
) (
  output logic clk,
  output logic arst_n
);

  initial begin
    clk = 1'b0;
    forever #(period_ns / 2.0) clk = ~clk;
  end

  // Release on a rising edge so no flop sees a partial reset
  initial begin
    arst_n = 1'b0;
    repeat (reset_cycles) @(posedge clk);
    arst_n <= 1'b1;
  end

endmodule

`default_nettype wire

/* tb_rv_core.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_rv_core;

  import rv_isa_pkg::*;
  import rv_pipe_pkg::*;

  localparam logic [31:0] lfsr_seed     = 32'hd668_4044;
  localparam int          cycles_per_op = 20;

  typedef struct packed {
    logic [31:0] pc;
    logic [31:0] word;
    logic [3:0]  rd;
    logic [31:0] rd_wdata;
    logic [31:0] next_pc;
  } vec_t;

  logic        clk;
  logic        arst_n;
  logic        inst_valid;
  logic        inst_ready;
  inst_t       inst;
  logic        retire_valid;
  logic        retire_ready;
  xw_t         retire;
  logic [31:0] lfsr;
  vec_t        vec_q[$];
  int          check_count;
  int          mismatch_count;
  int          other_count;

  tb_clk_gen #(
    .period_ns    (8.0),
    .reset_cycles (2)
  ) u_clk_gen (
    .clk    (clk),
    .arst_n (arst_n)
  );

  rv_core_top #(
    .n_gpr (16)
  ) i_dut (
    .clk          (clk),
    .arst_n       (arst_n),
    .inst_valid   (inst_valid),
    .inst_ready   (inst_ready),
    .inst         (inst),
    .retire_valid (retire_valid),
    .retire_ready (retire_ready),
    .retire       (retire)
  );

  // ============================================================
  // Instruction encoders and stimulus table
  // ============================================================

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [3:0] rs1,
                                        input logic [3:0] rd);
    enc_i = {imm, 1'b0, rs1, 3'b000, 1'b0, rd, 7'b0010011};
  endfunction

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [3:0] rs2,
                                        input logic [3:0] rs1, input logic [3:0] rd);
    enc_r = {f7, 1'b0, rs2, 1'b0, rs1, 3'b000, 1'b0, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] enc_lui(input logic [19:0] imm, input logic [3:0] rd);
    enc_lui = {imm, 1'b0, rd, 7'b0110111};
  endfunction

  // f3 001 is csrrw, 010 is csrrs
  function automatic logic [31:0] enc_csr(input logic [2:0] f3, input logic [11:0] csr,
                                          input logic [3:0] rs1, input logic [3:0] rd);
    enc_csr = {csr, 1'b0, rs1, f3, 1'b0, rd, 7'b1110011};
  endfunction

  task automatic push_vec(input logic [31:0] pc, input logic [31:0] word,
                          input logic [3:0] rd, input logic [31:0] wdata,
                          input logic [31:0] next_pc);
    vec_q.push_back({pc, word, rd, wdata, next_pc});
  endtask

  task automatic build_table();
    // Arithmetic with x0 written once and read back as zero
    push_vec(32'h100, enc_i(12'd5, 4'd0, 4'd1), 4'd1, 32'd5, 32'h104);
    push_vec(32'h104, enc_i(12'hffd, 4'd0, 4'd2), 4'd2, 32'hffff_fffd, 32'h108);
    push_vec(32'h108, enc_lui(20'h12345, 4'd3), 4'd3, 32'h1234_5000, 32'h10c);
    push_vec(32'h10c, enc_i(12'd7, 4'd0, 4'd0), 4'd0, 32'd7, 32'h110);
    push_vec(32'h110, enc_r(7'h00, 4'd2, 4'd1, 4'd4), 4'd4, 32'd2, 32'h114);
    push_vec(32'h114, enc_r(7'h20, 4'd2, 4'd1, 4'd5), 4'd5, 32'd8, 32'h118);
    push_vec(32'h118, enc_r(7'h00, 4'd0, 4'd3, 4'd6), 4'd6, 32'h1234_5000, 32'h11c);
    // Dependent chain through the interlock
    push_vec(32'h11c, enc_i(12'd10, 4'd4, 4'd7), 4'd7, 32'd12, 32'h120);
    push_vec(32'h120, enc_r(7'h00, 4'd7, 4'd7, 4'd7), 4'd7, 32'd24, 32'h124);
    push_vec(32'h124, enc_r(7'h20, 4'd5, 4'd7, 4'd8), 4'd8, 32'd16, 32'h128);
    push_vec(32'h128, enc_i(12'hfff, 4'd8, 4'd8), 4'd8, 32'd15, 32'h12c);
    // mtvec read and write
    push_vec(32'h12c, enc_lui(20'h00002, 4'd9), 4'd9, 32'h2000, 32'h130);
    push_vec(32'h130, enc_csr(3'b001, csr_mtvec, 4'd9, 4'd10), 4'd10, 32'h0, 32'h134);
    push_vec(32'h134, enc_i(12'h040, 4'd0, 4'd11), 4'd11, 32'h40, 32'h138);
    push_vec(32'h138, enc_csr(3'b010, csr_mtvec, 4'd11, 4'd12), 4'd12, 32'h2000, 32'h13c);
    push_vec(32'h13c, enc_csr(3'b010, csr_mtvec, 4'd0, 4'd13), 4'd13, 32'h2040, 32'h140);
    // ecall jumps to mtvec, then mepc and mstatus are read
    push_vec(32'h140, 32'h0000_0073, 4'd0, 32'h0, 32'h2040);
    push_vec(32'h2040, enc_csr(3'b010, csr_mepc, 4'd0, 4'd14), 4'd14, 32'h140, 32'h2044);
    push_vec(32'h2044, enc_csr(3'b010, csr_mstatus, 4'd0, 4'd15), 4'd15, 32'h1800, 32'h2048);
    // Return to the instruction after the ecall with MPIE set first
    push_vec(32'h2048, enc_i(12'd4, 4'd14, 4'd1), 4'd1, 32'h144, 32'h204c);
    push_vec(32'h204c, enc_csr(3'b001, csr_mepc, 4'd1, 4'd0), 4'd0, 32'h140, 32'h2050);
    push_vec(32'h2050, enc_i(12'h080, 4'd0, 4'd2), 4'd2, 32'h80, 32'h2054);
    push_vec(32'h2054, enc_csr(3'b010, csr_mstatus, 4'd2, 4'd0), 4'd0, 32'h1800, 32'h2058);
    push_vec(32'h2058, 32'h3020_0073, 4'd0, 32'h0, 32'h144);
    // MIE from MPIE, MPIE set, MPP cleared
    push_vec(32'h144, enc_csr(3'b010, csr_mstatus, 4'd0, 4'd3), 4'd3, 32'h88, 32'h148);
    push_vec(32'h148, enc_csr(3'b010, csr_mcause, 4'd0, 4'd4), 4'd4, 32'd11, 32'h14c);
    push_vec(32'h14c, enc_csr(3'b010, csr_mvendorid, 4'd0, 4'd5), 4'd5, mvendorid_value,
             32'h150);
    push_vec(32'h150, enc_csr(3'b010, csr_marchid, 4'd0, 4'd6), 4'd6, marchid_value,
             32'h154);
    push_vec(32'h154, enc_r(7'h00, 4'd3, 4'd4, 4'd7), 4'd7, 32'h93, 32'h158);
    push_vec(32'h158, enc_i(12'd0, 4'd0, 4'd0), 4'd0, 32'h0, 32'h15c);
  endtask

  // ============================================================
  // Checking
  // ============================================================

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    check_count++;
    if (got !== exp) begin
      mismatch_count++;
      $display("mismatch at %0.1f ns: %s got %h expected %h", $realtime, name, got, exp);
    end
  endtask

  task automatic print_counts();
    $display("checks %0d, mismatches %0d, other errors %0d",
             check_count, mismatch_count, other_count);
  endtask

  // Galois form of x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    if (state[0]) begin
      lfsr_next = (state >> 1) ^ 32'h8020_0003;
    end else begin
      lfsr_next = state >> 1;
    end
  endfunction

  // Handshake is sampled at the falling edge, inputs only move on the rising one
  task automatic drive_all();
    logic ready_seen;
    @(posedge clk);
    for (int i = 0; i < vec_q.size(); i++) begin
      inst_valid <= 1'b1;
      inst.pc    <= vec_q[i].pc;
      inst.word  <= vec_q[i].word;
      ready_seen = 1'b0;
      while (!ready_seen) begin
        @(negedge clk);
        ready_seen = inst_ready;
        @(posedge clk);
      end
    end
    inst_valid <= 1'b0;
    inst       <= '0;
  endtask

  task automatic collect_all();
    int idx;
    idx = 0;
    while (idx < vec_q.size()) begin
      @(negedge clk);
      if (retire_valid && retire_ready) begin
        check_value($sformatf("retire[%0d].pc", idx), retire.pc, vec_q[idx].pc);
        check_value($sformatf("retire[%0d].rd", idx), 32'(retire.rd), 32'(vec_q[idx].rd));
        check_value($sformatf("retire[%0d].rd_wdata", idx), retire.rd_wdata,
                    vec_q[idx].rd_wdata);
        check_value($sformatf("retire[%0d].next_pc", idx), retire.next_pc,
                    vec_q[idx].next_pc);
        idx++;
      end
    end
  endtask

  task automatic check_idle();
    @(posedge clk);
    repeat (4) begin
      @(negedge clk);
      if (retire_valid) begin
        other_count++;
        $display("extra retire record at %0.1f ns after the last table entry", $realtime);
      end
    end
  endtask

  // ============================================================
  // Processes
  // ============================================================

  initial begin : backpressure
    logic b0;
    logic b1;
    retire_ready = 1'b0;
    lfsr = lfsr_seed;
    forever begin
      @(posedge clk);
      b0 = lfsr[0];
      lfsr = lfsr_next(lfsr);
      b1 = lfsr[0];
      lfsr = lfsr_next(lfsr);
      retire_ready <= b0 | b1;
    end
  end

  initial begin : watchdog
    wait (arst_n === 1'b1);
    repeat (vec_q.size() * cycles_per_op) @(posedge clk);
    other_count++;
    $display("timeout: retirement did not finish within %0d cycles",
             vec_q.size() * cycles_per_op);
    print_counts();
    $display("tests failed");
    $finish;
  end

  initial begin : main
    check_count    = 0;
    mismatch_count = 0;
    other_count    = 0;
    inst_valid     = 1'b0;
    inst           = '0;
    build_table();
    wait (arst_n === 1'b1);
    fork
      drive_all();
      collect_all();
    join
    check_idle();
    print_counts();
    if (mismatch_count == 0 && other_count == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* vlog.f */
rv_isa_pkg.sv
rv_pipe_pkg.sv
rv_pipe_reg.sv
rv_decode.sv
rv_execute.sv
rv_gpr_csr.sv
rv_core_top.sv
tb_clk_gen.sv
tb_rv_core.sv

/* run.sh */
#!/bin/sh
# Build and run with Verilator, then search the log for the fail message
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f vlog.f --top-module tb_rv_core \
  && ./obj_dir/Vtb_rv_core > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }
cat sim.log
grep -qx "tests failed" sim.log && exit 1 || exit 0
